// File: Makefile
# Verilator simulation of the npc core testbench

VERILATOR ?= verilator
TOP       ?= tb_npc
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
src/npc_pkg.sv
src/npc_apb_if.sv
src/npc_idu.sv
src/npc_gpr.sv
src/npc_exu.sv
src/npc_ifu.sv
src/npc_lsu.sv
src/npc_apb_arbiter.sv
src/npc_top.sv
test/tb_mem.sv
test/tb_npc.sv

// File: src/npc_apb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module npc_apb_arbiter (
	input  logic      clk,
	input  logic      reset,
	npc_apb_if.slave  lsu_bus,
	npc_apb_if.slave  ifu_bus,
	npc_apb_if.master mem_bus
);
	import npc_pkg::*;

	logic active;
	logic grant_lsu;
	logic sel_lsu;
	logic xfer_end;

	// a new request is granted in its setup cycle and the lsu wins a tie
	assign sel_lsu  = active ? grant_lsu : lsu_bus.psel;
	assign xfer_end = mem_bus.psel && mem_bus.penable && mem_bus.pready;

	//////////////////////////////////////////////////
	// request mux
	//////////////////////////////////////////////////

	assign mem_bus.paddr   = sel_lsu ? lsu_bus.paddr   : ifu_bus.paddr;
	assign mem_bus.psel    = sel_lsu ? lsu_bus.psel    : ifu_bus.psel;
	assign mem_bus.penable = sel_lsu ? lsu_bus.penable : ifu_bus.penable;
	assign mem_bus.pwrite  = sel_lsu ? lsu_bus.pwrite  : ifu_bus.pwrite;
	assign mem_bus.pwdata  = sel_lsu ? lsu_bus.pwdata  : ifu_bus.pwdata;
	assign mem_bus.pstrb   = sel_lsu ? lsu_bus.pstrb   : ifu_bus.pstrb;

	//////////////////////////////////////////////////
	// response routing
	//////////////////////////////////////////////////

	// the waiting master sees a stalled bus
	assign lsu_bus.pready  = sel_lsu && mem_bus.pready;
	assign lsu_bus.prdata  = sel_lsu ? mem_bus.prdata : imm_zero;
	assign lsu_bus.pslverr = sel_lsu && mem_bus.pslverr;

	assign ifu_bus.pready  = !sel_lsu && mem_bus.pready;
	assign ifu_bus.prdata  = sel_lsu ? imm_zero : mem_bus.prdata;
	assign ifu_bus.pslverr = !sel_lsu && mem_bus.pslverr;

	always_ff @(posedge clk) begin
		if (reset) begin
			active    <= 1'b0;
			grant_lsu <= 1'b0;
		end else if (!active) begin
			if (lsu_bus.psel || ifu_bus.psel) begin
				active    <= 1'b1;
				grant_lsu <= lsu_bus.psel;
			end
		end else if (xfer_end) begin
			active <= 1'b0;
		end
	end

	// the granted master stays in its access phase until the transfer ends
	assert property (@(posedge clk) disable iff (reset)
		(mem_bus.psel && !xfer_end) |=> (mem_bus.psel && mem_bus.penable));

endmodule

`default_nettype wire

// File: src/npc_apb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface npc_apb_if;

	logic [31:0] paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [3:0]  pstrb;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	modport master (
		output paddr, psel, penable, pwrite, pwdata, pstrb,
		input  prdata, pready, pslverr
	);

	modport slave (
		input  paddr, psel, penable, pwrite, pwdata, pstrb,
		output prdata, pready, pslverr
	);

endinterface

`default_nettype wire

// File: src/npc_exu.sv
`timescale 1ns/1ps
`default_nettype none

module npc_exu (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            inst_valid,
	input  logic [npc_pkg::xlen-1:0]        pc,
	input  npc_pkg::opcode_t                inst_op,
	input  logic [2:0]                      inst_func3,
	input  logic                            inst_func7_b5,
	input  logic [npc_pkg::reg_addr_w-1:0]  inst_rd,
	input  logic [npc_pkg::xlen-1:0]        inst_imm,
	input  logic                            is_ebreak,
	input  logic [npc_pkg::xlen-1:0]        rdata1,
	input  logic [npc_pkg::xlen-1:0]        rdata2,
	input  logic                            lsu_done,
	input  logic [npc_pkg::xlen-1:0]        lsu_rdata,
	input  logic [npc_pkg::xlen-1:0]        a0,
	output logic                            retire,
	output logic [npc_pkg::xlen-1:0]        next_pc,
	output logic                            wen,
	output logic [npc_pkg::reg_addr_w-1:0]  waddr,
	output logic [npc_pkg::xlen-1:0]        wdata,
	output logic                            lsu_start,
	output logic                            lsu_write,
	output logic [npc_pkg::xlen-1:0]        lsu_addr,
	output logic [npc_pkg::xlen-1:0]        lsu_wdata,
	output logic                            halted,
	output logic [npc_pkg::xlen-1:0]        exit_code
);
	import npc_pkg::*;

	alu_op_t         alu_op;
	logic [xlen-1:0] alu_b, alu_res, pc_plus4;
	logic            is_mem, taken, started;

	//////////////////////////////////////////////////
	// alu
	//////////////////////////////////////////////////

	always_comb begin
		case (inst_func3)
			3'b000:  alu_op = (inst_op == op_r && inst_func7_b5) ? alu_sub : alu_add;
			3'b010:  alu_op = alu_slt;
			3'b100:  alu_op = alu_xor;
			3'b110:  alu_op = alu_or;
			3'b111:  alu_op = alu_and;
			default: alu_op = alu_add;
		endcase
	end

	assign alu_b = (inst_op == op_r) ? rdata2 : inst_imm;

	always_comb begin
		case (alu_op)
			alu_sub: alu_res = rdata1 - alu_b;
			alu_slt: alu_res = {31'b0, $signed(rdata1) < $signed(alu_b)};
			alu_xor: alu_res = rdata1 ^ alu_b;
			alu_or:  alu_res = rdata1 | alu_b;
			alu_and: alu_res = rdata1 & alu_b;
			default: alu_res = rdata1 + alu_b;
		endcase
	end

	// signed compares only, unsigned forms fall through as not taken
	always_comb begin
		case (inst_func3)
			3'b000:  taken = (rdata1 == rdata2);
			3'b001:  taken = (rdata1 != rdata2);
			3'b100:  taken = ($signed(rdata1) < $signed(rdata2));
			3'b101:  taken = ($signed(rdata1) >= $signed(rdata2));
			default: taken = 1'b0;
		endcase
	end

	assign pc_plus4 = pc + 32'd4;

	always_comb begin
		case (inst_op)
			op_j:    next_pc = pc + inst_imm;
			op_b:    next_pc = taken ? pc + inst_imm : pc_plus4;
			op_jr:   next_pc = (rdata1 + inst_imm) & ~32'd1;
			default: next_pc = pc_plus4;
		endcase
	end

	//////////////////////////////////////////////////
	// retire and writeback
	//////////////////////////////////////////////////

	assign is_mem = (inst_op == op_il) || (inst_op == op_s);

	// ebreak never retires, so the fetch unit parks in hold
	assign retire = inst_valid && !halted && !is_ebreak && (!is_mem || lsu_done);

	assign lsu_start = inst_valid && !halted && is_mem && !started;
	assign lsu_write = (inst_op == op_s);
	assign lsu_addr  = rdata1 + inst_imm;
	assign lsu_wdata = rdata2;

	always_comb begin
		case (inst_op)
			op_r, op_i:  wdata = alu_res;
			op_u:        wdata = inst_imm;
			op_upc:      wdata = pc + inst_imm;
			op_j, op_jr: wdata = pc_plus4;
			op_il:       wdata = lsu_rdata;
			default:     wdata = imm_zero;
		endcase
	end

	assign wen = retire && (inst_op inside {op_r, op_i, op_u, op_upc, op_j, op_jr, op_il});
	assign waddr = inst_rd;

	always_ff @(posedge clk) begin
		if (reset) begin
			started <= 1'b0;
			halted  <= 1'b0;
		end else begin
			if (lsu_start)
				started <= 1'b1;
			else if (lsu_done)
				started <= 1'b0;
			if (inst_valid && is_ebreak)
				halted <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (inst_valid && is_ebreak && !halted)
			exit_code <= a0;
	end

	assert property (@(posedge clk) disable iff (reset) !(retire && lsu_start));

endmodule

`default_nettype wire

// File: src/npc_gpr.sv
`timescale 1ns/1ps
`default_nettype none

module npc_gpr #(
	parameter int num_regs = 32
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [1:0]                      ren,
	input  logic [npc_pkg::reg_addr_w-1:0]  raddr1,
	input  logic [npc_pkg::reg_addr_w-1:0]  raddr2,
	input  logic                            wen,
	input  logic [npc_pkg::reg_addr_w-1:0]  waddr,
	input  logic [npc_pkg::xlen-1:0]        wdata,
	output logic [npc_pkg::xlen-1:0]        rdata1,
	output logic [npc_pkg::xlen-1:0]        rdata2,
	output logic [npc_pkg::xlen-1:0]        a0
);
	import npc_pkg::*;

	logic [xlen-1:0] regs [num_regs];

	// x0 and unimplemented registers read as zero
	assign rdata1 = (ren[0] && raddr1 != '0 && int'(raddr1) < num_regs) ? regs[raddr1] : imm_zero;
	assign rdata2 = (ren[1] && raddr2 != '0 && int'(raddr2) < num_regs) ? regs[raddr2] : imm_zero;

	assign a0 = regs[10];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= imm_zero;
		end else if (wen && waddr != '0 && int'(waddr) < num_regs) begin
			regs[waddr] <= wdata;
		end
	end

endmodule

`default_nettype wire

// File: src/npc_idu.sv
`timescale 1ns/1ps
`default_nettype none

module npc_idu (
	input  npc_pkg::inst_t                  inst,
	output npc_pkg::opcode_t                inst_op,
	output logic [npc_pkg::reg_addr_w-1:0]  inst_rd,
	output logic [npc_pkg::reg_addr_w-1:0]  raddr1,
	output logic [npc_pkg::reg_addr_w-1:0]  raddr2,
	output logic [2:0]                      inst_func3,
	output logic                            inst_func7_b5,
	output logic [npc_pkg::xlen-1:0]        inst_imm,
	output logic [1:0]                      ren,
	output logic                            is_ebreak
);
	import npc_pkg::*;

	logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

	assign inst_op       = opcode_t'(inst.rtype.opcode);
	assign inst_rd       = inst.rtype.rd;
	assign inst_func7_b5 = inst.rtype.funct7[5];
	assign raddr1        = inst.rtype.rs1;
	assign raddr2        = inst.rtype.rs2;

	// auipc and jal carry immediate bits where funct3 would be
	assign inst_func3 = (inst_op == op_upc || inst_op == op_j) ? 3'b000 : inst.rtype.funct3;

	//////////////////////////////////////////////////
	// immediates
	//////////////////////////////////////////////////

	assign imm_i = {{20{inst.raw[31]}}, inst.rtype.funct7, inst.rtype.rs2};
	assign imm_s = {{20{inst.raw[31]}}, inst.stype.imm_hi, inst.stype.imm_lo};
	// b-type scrambles the store fields
	assign imm_b = {{20{inst.raw[31]}}, inst.stype.imm_lo[0], inst.stype.imm_hi[5:0],
		inst.stype.imm_lo[4:1], 1'b0};
	assign imm_u = {inst.raw[31:12], 12'b0};
	assign imm_j = {{12{inst.raw[31]}}, inst.raw[19:12], inst.raw[20], inst.raw[30:21], 1'b0};

	always_comb begin
		case (inst_op)
			op_i, op_il, op_jr: inst_imm = imm_i;
			op_s:               inst_imm = imm_s;
			op_b:               inst_imm = imm_b;
			op_u, op_upc:       inst_imm = imm_u;
			op_j:               inst_imm = imm_j;
			default:            inst_imm = imm_zero;
		endcase
	end

	//////////////////////////////////////////////////
	// register file read enables
	//////////////////////////////////////////////////

	// bit 0 reads rs1, bit 1 reads rs2
	always_comb begin
		case (inst_op)
			op_r, op_b, op_s:   ren = 2'b11;
			op_i, op_il, op_jr: ren = 2'b01;
			default:            ren = 2'b00;
		endcase
	end

	assign is_ebreak = (inst_op == op_sys) && (inst.rtype.funct3 == 3'b000);

endmodule

`default_nettype wire

// File: src/npc_ifu.sv
`timescale 1ns/1ps
`default_nettype none

module npc_ifu #(
	parameter logic [31:0] reset_pc = 32'h0000_0000
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      retire,
	input  logic [npc_pkg::xlen-1:0]  next_pc,
	input  logic                      halted,
	output logic [npc_pkg::xlen-1:0]  pc,
	output npc_pkg::inst_t            inst,
	output logic                      inst_valid,
	npc_apb_if.master                 bus
);
	import npc_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_setup,
		st_access,
		st_hold
	} state_t;

	state_t state;

	// fetch is read only, the pc is the address
	assign bus.paddr   = pc;
	assign bus.psel    = (state == st_setup) || (state == st_access);
	assign bus.penable = (state == st_access);
	assign bus.pwrite  = 1'b0;
	assign bus.pwdata  = imm_zero;
	assign bus.pstrb   = 4'b0000;

	assign inst_valid = (state == st_hold);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			pc    <= reset_pc;
		end else begin
			case (state)
				st_idle:
					if (!halted)
						state <= st_setup;
				st_setup:
					state <= st_access;
				st_access:
					if (bus.pready)
						state <= st_hold;
				st_hold:
					if (retire && !halted) begin
						pc    <= next_pc;
						state <= st_setup;
					end
				default:
					state <= st_idle;
			endcase
		end
	end

	// instruction register
	always_ff @(posedge clk) begin
		if (state == st_access && bus.pready)
			inst <= bus.prdata;
	end

	assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: src/npc_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module npc_lsu (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      start,
	input  logic                      write,
	input  logic [npc_pkg::xlen-1:0]  addr,
	input  logic [npc_pkg::xlen-1:0]  wdata,
	output logic                      done,
	output logic [npc_pkg::xlen-1:0]  rdata,
	npc_apb_if.master                 bus
);
	import npc_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_setup,
		st_access
	} state_t;

	state_t          state;
	logic            busy;
	logic            write_q;
	logic [xlen-1:0] addr_q, wdata_q;

	assign busy = (state != st_idle);

	// word accesses only
	assign bus.paddr   = addr_q;
	assign bus.psel    = busy;
	assign bus.penable = (state == st_access);
	assign bus.pwrite  = write_q;
	assign bus.pwdata  = wdata_q;
	assign bus.pstrb   = write_q ? 4'b1111 : 4'b0000;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				st_idle:
					if (start)
						state <= st_setup;
				st_setup:
					state <= st_access;
				st_access:
					if (bus.pready) begin
						done  <= 1'b1;
						state <= st_idle;
					end
				default:
					state <= st_idle;
			endcase
		end
	end

	// request and response payload
	always_ff @(posedge clk) begin
		if (start && !busy) begin
			write_q <= write;
			addr_q  <= addr;
			wdata_q <= wdata;
		end
		if (state == st_access && bus.pready)
			rdata <= bus.prdata;
	end

	assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

`default_nettype wire

// File: src/npc_pkg.sv
`default_nettype none

package npc_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;

	localparam logic [xlen-1:0] imm_zero = 32'h0000_0000;

	// major opcodes, bits [6:0] of the instruction
	typedef enum logic [6:0] {
		op_r   = 7'b0110011,
		op_i   = 7'b0010011,
		op_il  = 7'b0000011,
		op_s   = 7'b0100011,
		op_b   = 7'b1100011,
		op_u   = 7'b0110111,
		op_upc = 7'b0010111,
		op_j   = 7'b1101111,
		op_jr  = 7'b1100111,
		op_sys = 7'b1110011
	} opcode_t;

	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_slt = 3'd2,
		alu_xor = 3'd3,
		alu_or  = 3'd4,
		alu_and = 3'd5
	} alu_op_t;

	// register layout and store layout of the same word
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} rtype;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} stype;
	} inst_t;

endpackage

`default_nettype wire

// File: src/npc_top.sv
`timescale 1ns/1ps
`default_nettype none

module npc_top #(
	parameter logic [31:0] reset_pc = 32'h0000_0000,
	parameter int          num_regs = 32
) (
	input  logic        clk,
	input  logic        reset,
	output logic [31:0] paddr,
	output logic        psel,
	output logic        penable,
	output logic        pwrite,
	output logic [31:0] pwdata,
	output logic [3:0]  pstrb,
	input  logic [31:0] prdata,
	input  logic        pready,
	input  logic        pslverr,
	output logic        halted,
	output logic [31:0] exit_code
);
	import npc_pkg::*;

	npc_apb_if ifu_bus ();
	npc_apb_if lsu_bus ();
	npc_apb_if mem_bus ();

	inst_t                 inst;
	opcode_t               inst_op;
	logic [xlen-1:0]       pc, next_pc, inst_imm;
	logic [xlen-1:0]       rdata1, rdata2, a0, wdata;
	logic [xlen-1:0]       lsu_addr, lsu_wdata, lsu_rdata;
	logic [reg_addr_w-1:0] inst_rd, raddr1, raddr2, waddr;
	logic [2:0]            inst_func3;
	logic [1:0]            ren;
	logic                  inst_valid, retire, inst_func7_b5, is_ebreak, wen;
	logic                  lsu_start, lsu_write, lsu_done;

	// external memory port
	assign paddr           = mem_bus.paddr;
	assign psel            = mem_bus.psel;
	assign penable         = mem_bus.penable;
	assign pwrite          = mem_bus.pwrite;
	assign pwdata          = mem_bus.pwdata;
	assign pstrb           = mem_bus.pstrb;
	assign mem_bus.prdata  = prdata;
	assign mem_bus.pready  = pready;
	assign mem_bus.pslverr = pslverr;

	npc_ifu #(.reset_pc(reset_pc)) u_ifu (
		.clk, .reset, .retire, .next_pc, .halted, .pc, .inst, .inst_valid,
		.bus(ifu_bus.master)
	);

	npc_idu u_idu (
		.inst, .inst_op, .inst_rd, .raddr1, .raddr2, .inst_func3, .inst_func7_b5,
		.inst_imm, .ren, .is_ebreak
	);

	npc_gpr #(.num_regs(num_regs)) u_gpr (
		.clk, .reset, .ren, .raddr1, .raddr2, .wen, .waddr, .wdata,
		.rdata1, .rdata2, .a0
	);

	npc_exu u_exu (
		.clk, .reset, .inst_valid, .pc, .inst_op, .inst_func3, .inst_func7_b5, .inst_rd,
		.inst_imm, .is_ebreak, .rdata1, .rdata2, .lsu_done, .lsu_rdata, .a0,
		.retire, .next_pc, .wen, .waddr, .wdata, .lsu_start, .lsu_write, .lsu_addr,
		.lsu_wdata, .halted, .exit_code
	);

	npc_lsu u_lsu (
		.clk, .reset, .start(lsu_start), .write(lsu_write), .addr(lsu_addr),
		.wdata(lsu_wdata), .done(lsu_done), .rdata(lsu_rdata), .bus(lsu_bus.master)
	);

	npc_apb_arbiter u_arbiter (
		.clk, .reset, .lsu_bus(lsu_bus.slave), .ifu_bus(ifu_bus.slave),
		.mem_bus(mem_bus.master)
	);

endmodule

`default_nettype wire

// File: test/tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	input  logic [3:0]  pstrb,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	localparam logic [6:0] op_imm   = 7'b0010011;
	localparam logic [6:0] op_load  = 7'b0000011;
	localparam logic [6:0] op_jalr  = 7'b1100111;
	localparam logic [6:0] op_lui   = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;

	logic [31:0] mem [1024];
	logic [31:0] rdata_q = 32'h0;
	logic        ready_q = 1'b0;
	int          waits = 0;

	// store log read by the testbench top
	logic [31:0] log_addr [64];
	logic [31:0] log_data [64];
	int          log_count = 0;
	int          proto_errors = 0;

	logic        prev_psel = 1'b0;
	logic        prev_penable = 1'b0;
	logic        prev_pready = 1'b0;
	logic        prev_pwrite = 1'b0;
	logic [31:0] prev_paddr = 32'h0;
	logic [31:0] prev_pwdata = 32'h0;

	assign prdata  = rdata_q;
	assign pready  = ready_q;
	assign pslverr = 1'b0;

	//////////////////////////////////////////////////
	// instruction encoders
	//////////////////////////////////////////////////

	function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
		input int f3, input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
		input int rd, input logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	// sw only
	function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
		input int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			7'b1100011};
	endfunction

	function automatic logic [31:0] u_type(input int imm20, input int rd, input logic [6:0] op);
		return {imm20[19:0], rd[4:0], op};
	endfunction

	function automatic logic [31:0] j_type(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	//////////////////////////////////////////////////
	// program image
	//////////////////////////////////////////////////

	initial begin
		for (int i = 0; i < 1024; i++)
			mem[i] = 32'hc0de_0000 | i;
		// x31 holds the result area base, x6 and x7 the operands
		mem[0]  = i_type(512, 0, 0, 31, op_imm);
		mem[1]  = i_type(100, 0, 0, 6, op_imm);
		mem[2]  = i_type(-37, 0, 0, 7, op_imm);
		mem[3]  = i_type(23, 6, 0, 8, op_imm);
		mem[4]  = s_type(0, 8, 31);
		mem[5]  = r_type(0, 7, 6, 0, 8);
		mem[6]  = s_type(4, 8, 31);
		mem[7]  = r_type(32, 7, 6, 0, 8);
		mem[8]  = s_type(8, 8, 31);
		mem[9]  = r_type(0, 6, 7, 2, 8);
		mem[10] = s_type(12, 8, 31);
		mem[11] = r_type(0, 7, 6, 4, 8);
		mem[12] = s_type(16, 8, 31);
		mem[13] = r_type(0, 7, 6, 6, 8);
		mem[14] = s_type(20, 8, 31);
		mem[15] = r_type(0, 7, 6, 7, 8);
		mem[16] = s_type(24, 8, 31);
		mem[17] = u_type(32'h12345, 8, op_lui);
		mem[18] = s_type(28, 8, 31);
		mem[19] = u_type(1, 8, op_auipc);
		mem[20] = s_type(32, 8, 31);
		// sum of 1 to 10 in x9
		mem[21] = i_type(0, 0, 0, 9, op_imm);
		mem[22] = i_type(1, 0, 0, 10, op_imm);
		mem[23] = i_type(11, 0, 0, 11, op_imm);
		mem[24] = r_type(0, 10, 9, 0, 9);
		mem[25] = i_type(1, 10, 0, 10, op_imm);
		mem[26] = b_type(-8, 11, 10, 4);
		mem[27] = s_type(36, 9, 31);
		mem[28] = u_type(32'he, 12, op_lui);
		mem[29] = i_type(-339, 12, 0, 12, op_imm);
		mem[30] = b_type(8, 0, 9, 1);
		mem[31] = s_type(40, 12, 31);
		mem[32] = j_type(32, 1);
		// load back slot 0, bump it, store to slot 12
		mem[33] = i_type(0, 31, 2, 13, op_load);
		mem[34] = i_type(1, 13, 0, 13, op_imm);
		mem[35] = s_type(48, 13, 31);
		mem[36] = i_type(42, 0, 0, 10, op_imm);
		mem[37] = 32'h0010_0073;
		// subroutine writes the marker and returns
		mem[40] = i_type(32'h5a5, 0, 0, 14, op_imm);
		mem[41] = s_type(44, 14, 31);
		mem[42] = i_type(0, 1, 0, 0, op_jalr);
	end

	//////////////////////////////////////////////////
	// APB slave with random wait states
	//////////////////////////////////////////////////

	always @(posedge clk) begin : slave_fsm
		int pick;
		if (reset) begin
			ready_q <= 1'b0;
			waits   <= 0;
		end else if (psel && !penable) begin
			pick = $urandom % 4;
			waits   <= pick;
			ready_q <= (pick == 0);
			rdata_q <= mem[paddr[11:2]];
		end else if (psel && penable) begin
			if (ready_q) begin
				ready_q <= 1'b0;
				if (pwrite) begin
					for (int b = 0; b < 4; b++)
						if (pstrb[b])
							mem[paddr[11:2]][8*b +: 8] <= pwdata[8*b +: 8];
					if (log_count < 64) begin
						log_addr[log_count] <= paddr;
						log_data[log_count] <= pwdata;
						log_count <= log_count + 1;
					end
				end
			end else begin
				waits   <= waits - 1;
				ready_q <= (waits == 1);
			end
		end
	end

	// protocol checks on the values of the cycle that just ended
	always @(posedge clk) begin
		if (reset) begin
			proto_errors = 0;
		end else begin
			if (penable && !prev_penable)
				assert (prev_psel) else begin
					proto_errors++;
					$display("penable rose without a setup cycle at %0t", $time);
				end
			if (prev_psel && prev_penable && !prev_pready)
				assert (paddr == prev_paddr && pwrite == prev_pwrite && pwdata == prev_pwdata)
				else begin
					proto_errors++;
					$display("request changed during wait states at %0t", $time);
				end
			if (psel)
				assert (paddr[1:0] == 2'b00) else begin
					proto_errors++;
					$display("unaligned address %h at %0t", paddr, $time);
				end
			// full word strobes on writes, none on reads
			if (psel)
				assert (pstrb == (pwrite ? 4'b1111 : 4'b0000)) else begin
					proto_errors++;
					$display("wrong strobe %b at %0t", pstrb, $time);
				end
		end
		prev_psel    = psel;
		prev_penable = penable;
		prev_pready  = pready;
		prev_pwrite  = pwrite;
		prev_paddr   = paddr;
		prev_pwdata  = pwdata;
	end

endmodule

`default_nettype wire

// File: test/tb_npc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_npc;

	localparam logic [31:0] reset_pc   = 32'h0000_0000;
	localparam logic [31:0] data_base  = 32'h0000_0200;
	localparam logic [31:0] auipc_addr = 32'h0000_004c;
	localparam int          num_slots  = 13;
	localparam int          skip_slot  = 10;
	localparam int          halt_limit = 20000;

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic [31:0] paddr, pwdata, prdata, exit_code;
	logic [3:0]  pstrb;
	logic        psel, penable, pwrite, pready, pslverr, halted;

	logic [31:0] expected [num_slots];
	int          seen [num_slots];
	int          errors = 0;
	bit          timed_out = 1'b0;

	always #20 clk = ~clk;

	npc_top #(.reset_pc(reset_pc), .num_regs(32)) uut (
		.clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata, .pstrb,
		.prdata, .pready, .pslverr, .halted, .exit_code
	);

	tb_mem mem_model (
		.clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata, .pstrb,
		.prdata, .pready, .pslverr
	);

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] want);
		assert (got === want) else begin
			errors++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	// result slots at data_base + 4 * index
	task automatic build_expected();
		logic signed [31:0] a, b;
		int sum;
		a = 100;
		b = -37;
		sum = 0;
		for (int i = 1; i <= 10; i++)
			sum += i;
		expected[0]  = a + 23;
		expected[1]  = a + b;
		expected[2]  = a - b;
		expected[3]  = (b < a) ? 32'd1 : 32'd0;
		expected[4]  = a ^ b;
		expected[5]  = a | b;
		expected[6]  = a & b;
		expected[7]  = 32'h12345 << 12;
		expected[8]  = auipc_addr + (32'h1 << 12);
		expected[9]  = sum;
		expected[10] = 32'hdead;
		expected[11] = 32'h5a5;
		expected[12] = expected[0] + 1;
	endtask

	task automatic expect_bus_quiet(input string when);
		check_value({"psel ", when}, 32'(psel), 32'd0);
		check_value({"penable ", when}, 32'(penable), 32'd0);
		check_value({"halted ", when}, 32'(halted), 32'd0);
	endtask

	task automatic apply_reset();
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			// outputs are known once the first reset edge has passed
			if (i > 0)
				expect_bus_quiet("in reset");
		end
		reset <= 1'b0;
		@(posedge clk);
		expect_bus_quiet("after reset");
	endtask

	task automatic catch_first_fetch();
		int n;
		n = 0;
		while (psel !== 1'b1 && n < 50) begin
			@(posedge clk);
			n++;
		end
		if (psel !== 1'b1) begin
			errors++;
			timed_out = 1'b1;
			$display("timeout waiting for the first fetch");
		end else begin
			check_value("penable in first setup", 32'(penable), 32'd0);
			check_value("first fetch address", paddr, reset_pc);
		end
	endtask

	task automatic wait_for_halt();
		int n;
		n = 0;
		while (halted !== 1'b1 && n < halt_limit) begin
			@(posedge clk);
			n++;
		end
		if (halted !== 1'b1) begin
			errors++;
			timed_out = 1'b1;
			$display("timeout waiting for halt");
		end
	endtask

	task automatic check_idle_after_halt();
		repeat (20) begin
			@(posedge clk);
			assert (psel === 1'b0) else begin
				errors++;
				$display("bus request after halt at %0t", $time);
			end
		end
		check_value("exit code", exit_code, 32'd42);
	endtask

	task automatic scan_store_log();
		logic [31:0] addr, data;
		int slot;
		for (int i = 0; i < num_slots; i++)
			seen[i] = 0;
		for (int k = 0; k < mem_model.log_count; k++) begin
			addr = mem_model.log_addr[k];
			data = mem_model.log_data[k];
			if (data == 32'hdead) begin
				errors++;
				$display("skipped-path store reached address %h", addr);
			end else if (addr >= data_base && addr < data_base + 4 * num_slots) begin
				slot = (addr - data_base) / 4;
				seen[slot]++;
				check_value($sformatf("store to %h", addr), data, expected[slot]);
			end else begin
				errors++;
				$display("store outside the result area at %h", addr);
			end
		end
		for (int i = 0; i < num_slots; i++)
			if (i != skip_slot)
				assert (seen[i] == 1) else begin
					errors++;
					$display("result slot %0d stored %0d times", i, seen[i]);
				end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		void'($urandom(32'hd05a));
		build_expected();
		apply_reset();
		catch_first_fetch();
		if (!timed_out)
			wait_for_halt();
		if (!timed_out) begin
			check_idle_after_halt();
			scan_store_log();
		end
		$display("errors: %0d value, %0d protocol", errors, mem_model.proto_errors);
		if (errors == 0 && mem_model.proto_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
